// File: Bender.yml
package:
  name: if_stage

sources:
  - fetch_pkg.sv
  - mem_bus_pkg.sv
  - refill_if.sv
  - pc_gen.sv
  - icache.sv
  - mem_req_arbiter.sv
  - if_stage.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_if_stage.sv

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // core-side widths
  localparam int addr_w = 64;
  localparam int inst_w = 32;

  localparam int inst_bytes = inst_w / 8;  // pc step per instruction

  // first fetch after reset
  localparam logic [addr_w-1:0] reset_pc = 64'h0000_0000_8000_0000;

  localparam logic [inst_w-1:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0

  // icache geometry
  localparam int line_bytes = 32;
  localparam int num_lines  = 16;
  localparam int offset_w   = $clog2(line_bytes);
  localparam int index_w    = $clog2(num_lines);
  localparam int tag_w      = addr_w - index_w - offset_w;

endpackage

`default_nettype wire

// File: icache.sv
`default_nettype none

module icache (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [fetch_pkg::addr_w-1:0] pc,
  input  logic                         flush,
  output logic [fetch_pkg::inst_w-1:0] inst,
  output logic                         hit,
  refill_if.cache                      refill
);

  localparam int beats_per_line = fetch_pkg::line_bytes * 8 / mem_bus_pkg::bus_data_w;
  localparam int beat_w         = $clog2(mem_bus_pkg::burst_beats);
  localparam int beat_lsb       = $clog2(mem_bus_pkg::bus_data_w / 8);
  localparam int word_w         = $clog2(mem_bus_pkg::bus_data_w / fetch_pkg::inst_w);
  localparam int word_lsb       = $clog2(fetch_pkg::inst_bytes);

  // line storage
  logic [fetch_pkg::tag_w-1:0]        tag_q   [fetch_pkg::num_lines];
  logic [fetch_pkg::num_lines-1:0]    valid_q;
  logic [mem_bus_pkg::bus_data_w-1:0] data_q  [fetch_pkg::num_lines][beats_per_line];

  logic [fetch_pkg::index_w-1:0]      pc_index;
  logic [fetch_pkg::tag_w-1:0]        pc_tag;
  logic [beat_w-1:0]                  pc_beat;
  logic [word_w-1:0]                  pc_word;
  logic [mem_bus_pkg::bus_data_w-1:0] rd_beat;
  logic                               lookup_hit;

  mem_bus_pkg::refill_state_e         state_q;
  logic [fetch_pkg::addr_w-1:0]       fill_addr_q;
  logic [fetch_pkg::index_w-1:0]      fill_index;
  logic [beat_w-1:0]                  beat_cnt_q;

  assign pc_index = pc[fetch_pkg::offset_w +: fetch_pkg::index_w];
  assign pc_tag   = pc[fetch_pkg::addr_w-1 -: fetch_pkg::tag_w];
  assign pc_beat  = pc[beat_lsb +: beat_w];
  assign pc_word  = pc[word_lsb +: word_w];

  // combinational lookup of the current pc
  assign rd_beat    = data_q[pc_index][pc_beat];
  assign lookup_hit = valid_q[pc_index] && (tag_q[pc_index] == pc_tag);

  assign hit  = lookup_hit && !flush;  // stale path never delivers
  assign inst = hit ? rd_beat[pc_word*fetch_pkg::inst_w +: fetch_pkg::inst_w]
                    : fetch_pkg::nop_inst;

  assign fill_index       = fill_addr_q[fetch_pkg::offset_w +: fetch_pkg::index_w];
  assign refill.req       = (state_q == mem_bus_pkg::refill_request);
  assign refill.line_addr = fill_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= mem_bus_pkg::refill_idle;
      beat_cnt_q <= '0;
      valid_q    <= '0;
    end else begin
      case (state_q)
        mem_bus_pkg::refill_idle: begin
          if (!lookup_hit) begin
            state_q <= mem_bus_pkg::refill_request;
          end
        end
        mem_bus_pkg::refill_request: begin
          valid_q[fill_index] <= 1'b0;  // line is being overwritten
          beat_cnt_q          <= '0;
          state_q             <= mem_bus_pkg::refill_fill;
        end
        mem_bus_pkg::refill_fill: begin
          if (refill.beat_valid) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (refill.last) begin
              valid_q[fill_index] <= 1'b1;
              state_q             <= mem_bus_pkg::refill_done;
            end
          end
        end
        mem_bus_pkg::refill_done: begin
          state_q <= mem_bus_pkg::refill_idle;  // lookup hits in this cycle
        end
        default: begin
          state_q <= mem_bus_pkg::refill_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == mem_bus_pkg::refill_idle) && !lookup_hit) begin
      fill_addr_q <= {pc[fetch_pkg::addr_w-1:fetch_pkg::offset_w],
                      {fetch_pkg::offset_w{1'b0}}};
    end
    if (state_q == mem_bus_pkg::refill_request) begin
      tag_q[fill_index] <= fill_addr_q[fetch_pkg::addr_w-1 -: fetch_pkg::tag_w];
    end
    if ((state_q == mem_bus_pkg::refill_fill) && refill.beat_valid) begin
      data_q[fill_index][beat_cnt_q] <= refill.beat_data;  // beats come in order
    end
  end

endmodule

`default_nettype wire

// File: if_stage.f
fetch_pkg.sv
mem_bus_pkg.sv
refill_if.sv
pc_gen.sv
icache.sv
mem_req_arbiter.sv
if_stage.sv
tb_mem_model.sv
tb_if_stage.sv

// File: if_stage.sv
`default_nettype none

module if_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  // pipeline control
  input  logic                               stall,
  input  logic                               redirect,
  input  logic [fetch_pkg::addr_w-1:0]       redirect_pc,
  // to decode
  output logic [fetch_pkg::inst_w-1:0]       inst,
  output logic [fetch_pkg::addr_w-1:0]       inst_pc,
  output logic                               inst_valid,
  // data side reads
  input  logic                               data_req,
  input  logic [fetch_pkg::addr_w-1:0]       data_addr,
  output logic                               data_rvalid,
  output logic [mem_bus_pkg::bus_data_w-1:0] data_rdata,
  // system bus read port
  output logic                               bus_req,
  output logic [fetch_pkg::addr_w-1:0]       bus_addr,
  output logic [mem_bus_pkg::bus_id_w-1:0]   bus_id,
  output logic                               bus_burst,
  input  logic                               r_valid,
  input  logic [mem_bus_pkg::bus_id_w-1:0]   r_id,
  input  logic [mem_bus_pkg::bus_data_w-1:0] r_data,
  input  logic                               r_last,
  input  logic                               w_busy
);

  logic [fetch_pkg::addr_w-1:0] pc;
  logic                         flush;
  logic                         hit;

  refill_if refill_bus ();

  pc_gen u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance     (hit),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc),
    .flush       (flush)
  );

  icache u_icache (
    .clk    (clk),
    .rst_n  (rst_n),
    .pc     (pc),
    .flush  (flush),
    .inst   (inst),
    .hit    (hit),
    .refill (refill_bus)
  );

  mem_req_arbiter u_mem_req_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .refill      (refill_bus),
    .data_req    (data_req),
    .data_addr   (data_addr),
    .data_rvalid (data_rvalid),
    .data_rdata  (data_rdata),
    .bus_req     (bus_req),
    .bus_addr    (bus_addr),
    .bus_id      (bus_id),
    .bus_burst   (bus_burst),
    .r_valid     (r_valid),
    .r_id        (r_id),
    .r_data      (r_data),
    .r_last      (r_last),
    .w_busy      (w_busy)
  );

  assign inst_pc    = pc;
  assign inst_valid = hit && !stall;  // inst itself stays up while stalled

endmodule

`default_nettype wire

// File: mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  localparam int bus_data_w = 64;
  localparam int bus_id_w   = 4;

  // returned beats are steered by these read ids
  localparam logic [bus_id_w-1:0] fetch_id = 4'd1;
  localparam logic [bus_id_w-1:0] data_id  = 4'd2;

  localparam int burst_beats = 4;  // one icache line

  // icache line refill
  typedef enum logic [1:0] {
    refill_idle,
    refill_request,
    refill_fill,
    refill_done
  } refill_state_e;

  // read port owner
  typedef enum logic [1:0] {
    arb_idle,
    arb_fetch_busy,
    arb_data_busy
  } arb_state_e;

endpackage

`default_nettype wire

// File: mem_req_arbiter.sv
`default_nettype none

module mem_req_arbiter (
  input  logic                               clk,
  input  logic                               rst_n,
  refill_if.arbiter                          refill,
  input  logic                               data_req,
  input  logic [fetch_pkg::addr_w-1:0]       data_addr,
  output logic                               data_rvalid,
  output logic [mem_bus_pkg::bus_data_w-1:0] data_rdata,
  output logic                               bus_req,
  output logic [fetch_pkg::addr_w-1:0]       bus_addr,
  output logic [mem_bus_pkg::bus_id_w-1:0]   bus_id,
  output logic                               bus_burst,
  input  logic                               r_valid,
  input  logic [mem_bus_pkg::bus_id_w-1:0]   r_id,
  input  logic [mem_bus_pkg::bus_data_w-1:0] r_data,
  input  logic                               r_last,
  input  logic                               w_busy
);

  mem_bus_pkg::arb_state_e      state_q;
  logic                         fetch_pend_q;
  logic                         data_pend_q;
  logic [fetch_pkg::addr_w-1:0] data_addr_q;
  logic                         fetch_beat;
  logic                         data_beat;
  logic                         issue_data;
  logic                         issue_fetch;
  logic                         xfer_done;

  // return path steered by id
  assign fetch_beat = r_valid && (r_id == mem_bus_pkg::fetch_id);
  assign data_beat  = r_valid && (r_id == mem_bus_pkg::data_id);

  assign refill.beat_valid = fetch_beat;
  assign refill.beat_data  = r_data;
  assign refill.last       = fetch_beat && r_last;
  assign data_rvalid       = data_beat;
  assign data_rdata        = r_data;

  // one read in flight, data side first, writes block new reads
  assign issue_data  = (state_q == mem_bus_pkg::arb_idle) && !w_busy && data_pend_q;
  assign issue_fetch = (state_q == mem_bus_pkg::arb_idle) && !w_busy && fetch_pend_q &&
                       !data_pend_q;

  assign bus_req   = issue_data || issue_fetch;
  assign bus_addr  = issue_data ? data_addr_q : refill.line_addr;
  assign bus_id    = issue_data ? mem_bus_pkg::data_id : mem_bus_pkg::fetch_id;
  assign bus_burst = issue_fetch;  // full line for fetch, single beat for data

  assign xfer_done = r_last &&
                     (((state_q == mem_bus_pkg::arb_fetch_busy) && fetch_beat) ||
                      ((state_q == mem_bus_pkg::arb_data_busy) && data_beat));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= mem_bus_pkg::arb_idle;
      fetch_pend_q <= 1'b0;
      data_pend_q  <= 1'b0;
    end else begin
      if (refill.req) begin
        fetch_pend_q <= 1'b1;
      end else if (issue_fetch) begin
        fetch_pend_q <= 1'b0;
      end

      if (data_req) begin
        data_pend_q <= 1'b1;
      end else if (issue_data) begin
        data_pend_q <= 1'b0;
      end

      case (state_q)
        mem_bus_pkg::arb_idle: begin
          if (issue_data) begin
            state_q <= mem_bus_pkg::arb_data_busy;
          end else if (issue_fetch) begin
            state_q <= mem_bus_pkg::arb_fetch_busy;
          end
        end
        mem_bus_pkg::arb_fetch_busy,
        mem_bus_pkg::arb_data_busy: begin
          if (xfer_done) begin
            state_q <= mem_bus_pkg::arb_idle;
          end
        end
        default: begin
          state_q <= mem_bus_pkg::arb_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (data_req) begin
      data_addr_q <= data_addr;
    end
  end

endmodule

`default_nettype wire

// File: pc_gen.sv
`default_nettype none

module pc_gen (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         advance,
  input  logic                         stall,
  input  logic                         redirect,
  input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
  output logic [fetch_pkg::addr_w-1:0] pc,
  output logic                         flush
);

  localparam logic [fetch_pkg::addr_w-1:0] pc_step = fetch_pkg::inst_bytes;

  logic [fetch_pkg::addr_w-1:0] pc_next;

  always_comb begin
    pc_next = pc;
    if (redirect) begin
      pc_next = redirect_pc;  // wins over stall
    end else if (advance && !stall) begin
      pc_next = pc + pc_step;
    end
  end

  // flush covers the fetch of the old path still in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= fetch_pkg::reset_pc;
      flush <= 1'b0;
    end else begin
      pc    <= pc_next;
      flush <= redirect;
    end
  end

endmodule

`default_nettype wire

// File: refill_if.sv
`default_nettype none

interface refill_if;

  logic                               req;        // one cycle per line
  logic [fetch_pkg::addr_w-1:0]       line_addr;  // held until last
  logic                               beat_valid;
  logic [mem_bus_pkg::bus_data_w-1:0] beat_data;
  logic                               last;

  modport cache (
    output req,
    output line_addr,
    input  beat_valid,
    input  beat_data,
    input  last
  );

  modport arbiter (
    input  req,
    input  line_addr,
    output beat_valid,
    output beat_data,
    output last
  );

endinterface

`default_nettype wire

// File: tb_if_stage.sv
`default_nettype none

module tb_if_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int aw         = fetch_pkg::addr_w;
  localparam int max_cycles = 4000;
  localparam logic [aw-1:0] loop_base  = 64'h0000_0000_8000_2000;  // 8 instructions in one line
  localparam logic [aw-1:0] split_line = 64'h0000_0000_8010_0040;
  localparam logic [aw-1:0] busy_line  = 64'h0000_0000_8020_0080;

  logic                               clk, rst_n;
  logic                               stall, redirect, data_req, w_busy;
  logic [aw-1:0]                      redirect_pc, data_addr, inst_pc, bus_addr;
  logic [fetch_pkg::inst_w-1:0]       inst, exp_inst;
  logic                               inst_valid, data_rvalid, bus_req, bus_burst;
  logic [mem_bus_pkg::bus_data_w-1:0] data_rdata, r_data;
  logic [mem_bus_pkg::bus_id_w-1:0]   bus_id, r_id;
  logic                               r_valid, r_last;

  int seed = 72861;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int fetch_reqs = 0;

  // last cycle's view for pc sequencing
  logic          after_reset, prev_valid, prev_stall, prev_redirect;
  logic [aw-1:0] prev_pc, prev_target;

  if_stage DUT (.*);

  tb_mem_model u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] mem_word(input logic [63:0] a);
    logic [31:0] lo;
    lo = a[31:0];
    return (lo * 32'h9e37_79b1) ^ a[63:32] ^ {lo[7:0], lo[31:8]};
  endfunction

  assign exp_inst = mem_word(inst_pc);

  inst_matches_memory: assert property (
    @(posedge clk) disable iff (!rst_n) inst_valid |-> inst == exp_inst
  ) else begin
    $display("** Error @%0t: inst expected %h got %h", $time, $sampled(exp_inst), $sampled(inst));
    errors++;
  end

  fetch_is_line_burst: assert property (
    @(posedge clk) disable iff (!rst_n)
    bus_req && bus_id == mem_bus_pkg::fetch_id |->
      bus_burst && bus_addr[fetch_pkg::offset_w-1:0] == '0
  ) else begin
    $display("fetch request at %0t is not a line-aligned burst", $time);
    errors++;
  end

  no_req_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) w_busy |-> !bus_req
  ) else begin
    $display("bus_req raised while w_busy was high at %0t", $time);
    errors++;
  end

  task automatic expect_pc(input logic [aw-1:0] got, input logic [aw-1:0] want);
    checks++;
    assert (got == want) else begin
      $display("** Error @%0t: inst_pc expected %h got %h", $time, want, got);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n || after_reset) begin
      checks++;
      assert (!bus_req && !data_rvalid && !inst_valid) else begin
        $display("bus_req, data_rvalid or inst_valid active around reset at %0t", $time);
        errors++;
      end
    end
    if (rst_n && prev_redirect) begin
      checks++;
      assert (!inst_valid) else begin
        $display("** Error @%0t: inst_valid expected 0 got %b", $time, inst_valid);
        errors++;
      end
      assert (inst == fetch_pkg::nop_inst) else begin
        $display("** Error @%0t: inst expected %h got %h", $time, fetch_pkg::nop_inst, inst);
        errors++;
      end
      expect_pc(inst_pc, prev_target);
    end else if (rst_n && prev_valid) begin
      expect_pc(inst_pc, prev_pc + 4);
    end else if (rst_n && prev_stall) begin
      expect_pc(inst_pc, prev_pc);  // held by stall
    end
    if (rst_n && bus_req && bus_id == mem_bus_pkg::fetch_id) begin
      fetch_reqs++;
    end
    after_reset   <= !rst_n;
    prev_valid    <= rst_n && inst_valid;
    prev_stall    <= rst_n && stall;
    prev_redirect <= rst_n && redirect;
    prev_pc       <= inst_pc;
    prev_target   <= redirect_pc;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic next_valid_pc(output logic [aw-1:0] pc);
    do begin
      @(posedge clk);
    end while (!inst_valid);
    pc = inst_pc;
  endtask

  task automatic jump_to(input logic [aw-1:0] target, input logic hold);
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = target;
    stall       = hold;
    @(negedge clk);
    redirect = 1'b0;
    stall    = 1'b0;
  endtask

  // redirect away while the last word of the loop line is on the outputs
  task automatic finish_pass(input logic [aw-1:0] target);
    do begin
      @(negedge clk);
    end while (!(inst_valid && inst_pc == loop_base + 28));
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect = 1'b0;
  endtask

  task automatic end_test(input string name, input int start);
    $display("test %0s finished with %0d errors", name, errors - start);
  endtask

  initial begin
    logic [aw-1:0] pc;
    logic [aw-1:0] target;
    logic [aw-1:0] rd_addr;
    int            start;
    int            base_reqs;
    int            i;

    rst_n       = 1'b0;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    data_req    = 1'b0;
    data_addr   = '0;
    w_busy      = 1'b0;

    start = errors;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    next_valid_pc(pc);
    expect_pc(pc, fetch_pkg::reset_pc);
    end_test("reset", start);

    start = errors;
    repeat (40) next_valid_pc(pc);  // five lines
    checks++;
    assert (fetch_reqs == 6) else begin  // reset line plus five more
      $display("** Error @%0t: fetch_reqs expected 6 got %0d", $time, fetch_reqs);
      errors++;
    end
    end_test("sequential fetch", start);

    start = errors;
    for (i = 0; i < 60; i++) begin
      @(negedge clk);
      stall = ($random(seed) & 3) == 0;
    end
    for (i = 0; i < 4; i++) begin
      target = 64'h8000_1000 + ($random(seed) & 32'hffc);
      jump_to(target, i[0]);  // odd ones land on a stall
      next_valid_pc(pc);
      expect_pc(pc, target);
    end
    end_test("stall and redirect", start);

    start = errors;
    jump_to(loop_base, 1'b0);
    finish_pass(loop_base);  // first pass fills the line
    base_reqs = fetch_reqs;
    repeat (3) finish_pass(loop_base);
    checks++;
    assert (fetch_reqs == base_reqs) else begin
      $display("%0d fetch refills issued for a loop already cached", fetch_reqs - base_reqs);
      errors++;
    end
    end_test("cache hits", start);

    start = errors;
    rd_addr = 64'h9000_0000 + ($random(seed) & 32'hff8);
    finish_pass(split_line);
    @(negedge clk);
    data_req  = 1'b1;  // same cycle as the icache refill req
    data_addr = rd_addr;
    @(negedge clk);
    data_req = 1'b0;
    do begin
      @(posedge clk);
    end while (!bus_req);
    checks++;
    assert (bus_id == mem_bus_pkg::data_id) else begin
      $display("** Error @%0t: bus_id expected %h got %h", $time, mem_bus_pkg::data_id, bus_id);
      errors++;
    end
    do begin
      @(posedge clk);
    end while (!data_rvalid);
    checks++;
    assert (data_rdata == {mem_word(rd_addr + 4), mem_word(rd_addr)}) else begin
      $display("** Error @%0t: data_rdata expected %h got %h", $time,
               {mem_word(rd_addr + 4), mem_word(rd_addr)}, data_rdata);
      errors++;
    end
    next_valid_pc(pc);
    expect_pc(pc, split_line);

    @(negedge clk);
    w_busy      = 1'b1;
    redirect    = 1'b1;
    redirect_pc = busy_line;
    @(negedge clk);
    redirect = 1'b0;
    repeat (12) @(negedge clk);
    w_busy = 1'b0;
    next_valid_pc(pc);
    expect_pc(pc, busy_line);
    end_test("arbitration", start);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

module tb_mem_model (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               bus_req,
  input  logic [fetch_pkg::addr_w-1:0]       bus_addr,
  input  logic [mem_bus_pkg::bus_id_w-1:0]   bus_id,
  input  logic                               bus_burst,
  output logic                               r_valid,
  output logic [mem_bus_pkg::bus_id_w-1:0]   r_id,
  output logic [mem_bus_pkg::bus_data_w-1:0] r_data,
  output logic                               r_last
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int latency = 3;  // req edge to first beat

  // 32-bit word stored at byte address a
  function automatic logic [31:0] word_at(input logic [63:0] a);
    logic [31:0] lo;
    lo = a[31:0];
    return (lo * 32'h9e37_79b1) ^ a[63:32] ^ {lo[7:0], lo[31:8]};
  endfunction

  initial begin
    logic [63:0] addr;
    logic [3:0]  id;
    int          beats;
    int          i;
    r_valid = 1'b0;
    r_id    = '0;
    r_data  = '0;
    r_last  = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n && bus_req) begin
        addr  = {bus_addr[63:3], 3'b000};
        id    = bus_id;
        beats = bus_burst ? mem_bus_pkg::burst_beats : 1;
        repeat (latency - 1) @(posedge clk);
        for (i = 0; i < beats; i++) begin
          @(negedge clk);
          r_valid = 1'b1;
          r_id    = id;
          r_data  = {word_at(addr + i * 8 + 4), word_at(addr + i * 8)};  // low word first
          r_last  = (i == beats - 1);
        end
        @(negedge clk);
        r_valid = 1'b0;
        r_last  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
